//--- files.f
common/video_pkg.sv
common/traffic_pkg.sv
traffic_regs/traffic_regs.sv
traffic_regs/lane_motion.sv
vehicle_painter/car_rom.sv
vehicle_painter/vehicle_painter.sv
source/traffic_layer.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_traffic_layer.sv

//--- run.sh
#!/bin/sh
# build and run the traffic layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_traffic_layer \
    -f files.f \
    -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation passed"

//--- dv/tb_traffic_layer.sv
module tb_traffic_layer;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {APB_WR, APB_RD, FRAME, PIXEL} op_t;

    typedef struct packed {
        op_t         op;
        logic [9:0]  a;     // register address or column
        logic [9:0]  b;     // row
        logic [31:0] data;
        logic [31:0] exp;
        logic        err;
    } step_t;

    logic                    clk;
    logic                    arst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    traffic_pkg::apb_addr_t  paddr;
    traffic_pkg::apb_data_t  pwdata;
    traffic_pkg::apb_data_t  prdata;
    logic                    pready;
    logic                    pslverr;
    video_pkg::pixel_coord_t col_pos;
    video_pkg::pixel_coord_t row_pos;
    logic                    pixel_valid;
    logic                    frame_start;
    video_pkg::color_t       color;
    logic                    color_valid;
    traffic_pkg::apb_data_t  exp_data;
    logic                    exp_err;
    video_pkg::color_t       exp_color;
    int                      step_idx;
    logic                    done;
    int                      pass_count;
    int                      fail_count;
    int                      cycles = 0;
    int                      cycle_limit = 0;
    step_t                   steps[$];
    // lane state as the random section programs it
    int                      model_x[traffic_pkg::NUM_LANES];
    int                      model_len[traffic_pkg::NUM_LANES];

    tb_clock clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    traffic_layer dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .col_pos     (col_pos),
        .row_pos     (row_pos),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start),
        .color       (color),
        .color_valid (color_valid)
    );

    tb_checker checker_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .pixel_valid (pixel_valid),
        .color       (color),
        .color_valid (color_valid),
        .exp_data    (exp_data),
        .exp_err     (exp_err),
        .exp_color   (exp_color),
        .step_idx    (step_idx),
        .done        (done),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    function automatic void add_step(op_t op, int a, int b, int data, int exp, bit err);
        step_t s;
        s.op   = op;
        s.a    = a[9:0];
        s.b    = b[9:0];
        s.data = data;
        s.exp  = exp;
        s.err  = err;
        steps.push_back(s);
    endfunction

    // expected colour from the painter rules for the lanes in the model
    function automatic video_pkg::color_t ref_color(int col, int row);
        int hit;
        int lx;
        int ly;
        int len;
        hit = -1;
        // scan downwards so the lowest lane is the one left in hit
        for (int n = traffic_pkg::NUM_LANES - 1; n >= 0; n--) begin
            if (row >= 256 + 32 * n && row < 288 + 32 * n &&
                col >= model_x[n] && col < model_x[n] + model_len[n]) begin
                hit = n;
            end
        end
        if (hit < 0 || col < 96 || col >= 544) begin
            return 6'b000000;
        end
        len = model_len[hit];
        lx  = col - model_x[hit];
        ly  = row - (256 + 32 * hit);
        if (len > 64) begin
            if (ly >= 24) begin
                if ((lx >= 4 && lx <= 8) || (lx >= len - 9 && lx <= len - 5)) begin
                    return video_pkg::WHEEL_COL;
                end
                return video_pkg::TRUCK_BODY;
            end
            if (ly < 10 || lx < len - 32) begin
                return video_pkg::TRUCK_BODY;
            end
            if (ly >= 12 && ly <= 16 && lx >= len - 28 && lx <= len - 20) begin
                return video_pkg::WINDOW_COL;
            end
            return video_pkg::TRUCK_CAB;
        end
        if (len == 64) begin
            // top layer first
            if (ly >= 24 && ((lx >= 9 && lx <= 14) || (lx >= 46 && lx <= 52))) begin
                return video_pkg::WHEEL_COL;
            end
            if ((ly >= 18 && ly <= 22 && lx >= 59) ||
                (ly >= 6 && ly <= 14 && lx >= 48 && lx <= 60) ||
                (ly >= 8 && ly <= 13 && ((lx >= 8 && lx <= 20) || (lx >= 24 && lx <= 36)))) begin
                return video_pkg::WINDOW_COL;
            end
            if (ly == 18 && lx >= 8 && lx < 56) begin
                return video_pkg::STRIPE_2;
            end
            if (ly >= 14 && ly <= 17 && lx >= 4 && lx < 60) begin
                return video_pkg::STRIPE_1;
            end
            if (ly < 4 && lx >= 4 && lx < 60) begin
                return video_pkg::RV_ROOF;
            end
            return video_pkg::RV_BODY;
        end
        // car sprite
        if (ly >= 26 && ((lx >= 3 && lx <= 8) || (lx >= 23 && lx <= 28))) begin
            return video_pkg::WHEEL_COL;
        end
        if (ly >= 8 && ly <= 13 && lx >= 10 && lx <= 21) begin
            return video_pkg::WINDOW_COL;
        end
        if (ly <= 5) begin
            return video_pkg::CAR_ROOF;
        end
        return video_pkg::CAR_BODY;
    endfunction

    function automatic void build_table();
        // reset values
        add_step(APB_RD, 'h00, 0, 0, 96, 0);
        add_step(APB_RD, 'h04, 0, 0, 32, 0);
        add_step(APB_RD, 'h58, 0, 0, 0, 0);
        add_step(APB_RD, 'h60, 0, 0, 0, 0);
        // lane 1 becomes a truck at 200 with speed -3
        add_step(APB_WR, 'h10, 0, 200, 0, 0);
        add_step(APB_RD, 'h10, 0, 0, 200, 0);
        add_step(APB_WR, 'h14, 0, 96, 0, 0);
        add_step(APB_RD, 'h14, 0, 0, 96, 0);
        add_step(APB_WR, 'h18, 0, 'h3d, 0, 0);
        add_step(APB_RD, 'h18, 0, 0, 32'hffff_fffd, 0);
        // unaligned and out of map
        add_step(APB_RD, 'h13, 0, 0, 0, 1);
        add_step(APB_RD, 'h64, 0, 0, 0, 1);
        add_step(APB_WR, 'h70, 0, 1, 0, 1);
        add_step(APB_WR, 'h61, 0, 1, 0, 1);
        add_step(APB_RD, 'h60, 0, 0, 0, 0);
        // lane 2 RV at 300, lane 3 car left of the playfield
        add_step(APB_WR, 'h20, 0, 300, 0, 0);
        add_step(APB_WR, 'h24, 0, 64, 0, 0);
        add_step(APB_WR, 'h30, 0, 60, 0, 0);
        // truck: wheel, cab window, trailer, cab
        add_step(PIXEL, 205, 316, 0, video_pkg::WHEEL_COL, 0);
        add_step(PIXEL, 270, 302, 0, video_pkg::WINDOW_COL, 0);
        add_step(PIXEL, 220, 303, 0, video_pkg::TRUCK_BODY, 0);
        add_step(PIXEL, 290, 308, 0, video_pkg::TRUCK_CAB, 0);
        // RV layers
        add_step(PIXEL, 302, 322, 0, video_pkg::RV_BODY, 0);
        add_step(PIXEL, 310, 321, 0, video_pkg::RV_ROOF, 0);
        add_step(PIXEL, 330, 336, 0, video_pkg::STRIPE_1, 0);
        add_step(PIXEL, 330, 338, 0, video_pkg::STRIPE_2, 0);
        add_step(PIXEL, 310, 330, 0, video_pkg::WINDOW_COL, 0);
        add_step(PIXEL, 350, 327, 0, video_pkg::WINDOW_COL, 0);
        add_step(PIXEL, 361, 340, 0, video_pkg::WINDOW_COL, 0);
        add_step(PIXEL, 310, 346, 0, video_pkg::WHEEL_COL, 0);
        // car sprite rules, then misses
        add_step(PIXEL, 101, 284, 0, video_pkg::WHEEL_COL, 0);
        add_step(PIXEL, 111, 266, 0, video_pkg::WINDOW_COL, 0);
        add_step(PIXEL, 111, 258, 0, video_pkg::CAR_ROOF, 0);
        add_step(PIXEL, 111, 276, 0, video_pkg::CAR_BODY, 0);
        add_step(PIXEL, 140, 276, 0, 0, 0);
        add_step(PIXEL, 70, 360, 0, 0, 0);
        add_step(PIXEL, 111, 200, 0, 0, 0);
        add_step(PIXEL, 100, 460, 0, 0, 0);
        // stream across lanes with one gap
        add_step(PIXEL, 100, 390, 0, video_pkg::CAR_BODY, 0);
        add_step(PIXEL, 112, 428, 0, video_pkg::WINDOW_COL, 0);
        add_step(PIXEL, 290, 308, 0, video_pkg::TRUCK_CAB, 0);
        add_step(PIXEL, 100, 360, 0, 0, 0);
        add_step(APB_RD, 'h20, 0, 0, 300, 0);
        add_step(PIXEL, 310, 346, 0, video_pkg::WHEEL_COL, 0);
        // lane 4 heads right at +10, lane 5 left at -7 with length 40
        add_step(APB_WR, 'h40, 0, 530, 0, 0);
        add_step(APB_WR, 'h48, 0, 10, 0, 0);
        add_step(APB_WR, 'h50, 0, 100, 0, 0);
        add_step(APB_WR, 'h54, 0, 40, 0, 0);
        add_step(APB_WR, 'h58, 0, 'h39, 0, 0);
        add_step(FRAME, 0, 0, 0, 0, 0);
        add_step(APB_RD, 'h10, 0, 0, 200, 0);
        add_step(APB_RD, 'h40, 0, 0, 530, 0);
        add_step(APB_WR, 'h60, 0, 1, 0, 0);
        add_step(APB_RD, 'h60, 0, 0, 1, 0);
        add_step(FRAME, 0, 0, 0, 0, 0);
        add_step(APB_RD, 'h10, 0, 0, 197, 0);
        add_step(APB_RD, 'h40, 0, 0, 540, 0);
        add_step(APB_RD, 'h50, 0, 0, 504, 0);
        add_step(APB_RD, 'h20, 0, 0, 300, 0);
        add_step(FRAME, 0, 0, 0, 0, 0);
        add_step(APB_RD, 'h40, 0, 0, 96, 0);
        add_step(APB_RD, 'h50, 0, 0, 497, 0);
        add_step(APB_RD, 'h10, 0, 0, 194, 0);
        add_step(APB_WR, 'h60, 0, 0, 0, 0);
    endfunction

    // random lanes, then random probes around them
    function automatic void add_random(int count);
        int pick;
        int lane;
        int col;
        int row;
        for (int n = 0; n < traffic_pkg::NUM_LANES; n++) begin
            pick       = int'($urandom_range(2));
            model_x[n] = 40 + int'($urandom_range(480));
            if (pick == 0) begin
                model_len[n] = 16 + int'($urandom_range(16));
            end else if (pick == 1) begin
                model_len[n] = 64;
            end else begin
                model_len[n] = 65 + int'($urandom_range(95));
            end
            add_step(APB_WR, 16 * n, 0, model_x[n], 0, 0);
            add_step(APB_WR, 16 * n + 4, 0, model_len[n], 0, 0);
        end
        for (int i = 0; i < count; i++) begin
            lane = int'($urandom_range(5));
            row  = 256 + 32 * lane + int'($urandom_range(31));
            col  = model_x[lane] - 8 + int'($urandom_range(model_len[lane] + 15));
            add_step(PIXEL, col, row, 0, int'(ref_color(col, row)), 0);
        end
    endfunction

    function automatic void release_bus();
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pixel_valid = 1'b0;
        frame_start = 1'b0;
    endfunction

    task automatic apply(step_t s, int idx);
        @(negedge clk);
        release_bus();
        step_idx = idx;
        case (s.op)
            APB_WR, APB_RD: begin
                psel     = 1'b1;
                pwrite   = (s.op == APB_WR);
                paddr    = s.a[7:0];
                pwdata   = s.data;
                exp_data = s.exp;
                exp_err  = s.err;
                @(negedge clk);
                penable = 1'b1;
            end
            FRAME: frame_start = 1'b1;
            default: begin
                col_pos     = s.a;
                row_pos     = s.b;
                exp_color   = s.exp[5:0];
                pixel_valid = 1'b1;
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run hung: timeout after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        release_bus();
        paddr     = '0;
        pwdata    = '0;
        col_pos   = '0;
        row_pos   = '0;
        exp_data  = '0;
        exp_err   = 1'b0;
        exp_color = '0;
        step_idx  = 0;
        done      = 1'b0;
        void'($urandom(32'hb317_7639));
        build_table();
        add_random(40);
        cycle_limit = 20 * steps.size() + 1000;
        @(posedge arst_n);
        foreach (steps[i]) begin
            apply(steps[i], i);
        end
        @(negedge clk);
        release_bus();
        // the last pixel leaves the output register one cycle later
        repeat (2) @(negedge clk);
        done = 1'b1;
        @(negedge clk);
        // a run that compared nothing counts as failed
        if (fail_count == 0 && pass_count > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- dv/tb_checker.sv
module tb_checker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  traffic_pkg::apb_data_t prdata,
    input  logic                   pready,
    input  logic                   pslverr,
    input  logic                   pixel_valid,
    input  video_pkg::color_t      color,
    input  logic                   color_valid,
    input  traffic_pkg::apb_data_t exp_data,
    input  logic                   exp_err,
    input  video_pkg::color_t      exp_color,
    input  int                     step_idx,
    input  logic                   done,
    output int                     pass_count,
    output int                     fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int                passes = 0;
    int                fails = 0;
    logic              pend_valid = 1'b0;
    video_pkg::color_t pend_color = '0;
    int                pend_idx = 0;

    assign pass_count = passes;
    assign fail_count = fails;

    task automatic compare(string name, int idx, logic [31:0] exp, logic [31:0] act);
        if (exp === act) begin
            passes++;
            $display("test %0d ok: %s = %h", idx, name, act);
        end else begin
            fails++;
            $display("Fail at %0d ns: test %0d %s expected %h actual %h",
                     $time, idx, name, exp, act);
        end
    endtask

    // inputs settle at the falling edge, registered outputs hold until the NBA region
    always @(posedge clk) begin
        if (arst_n) begin
            // access cycle of an APB transfer, no wait states
            if (psel && penable) begin
                compare("pready", step_idx, 32'd1, {31'b0, pready});
                compare("pslverr", step_idx, {31'b0, exp_err}, {31'b0, pslverr});
                if (!pwrite) begin
                    compare("prdata", step_idx, exp_data, prdata);
                end
            end
            // colour must follow its pixel by exactly one cycle
            if (color_valid !== pend_valid) begin
                fails++;
                $display("Fail at %0d ns: test %0d color_valid expected %b actual %b",
                         $time, pend_idx, pend_valid, color_valid);
            end else if (color_valid) begin
                compare("color", pend_idx, {26'b0, pend_color}, {26'b0, color});
            end
            pend_valid = pixel_valid;
            pend_color = exp_color;
            pend_idx   = step_idx;
        end
    end

    always @(posedge done) begin
        $display("checks passed: %0d, failed: %0d", passes, fails);
    end

endmodule

//--- dv/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for ten cycles, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- source/traffic_layer.sv
module traffic_layer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  traffic_pkg::apb_addr_t  paddr,
    input  traffic_pkg::apb_data_t  pwdata,
    output traffic_pkg::apb_data_t  prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  video_pkg::pixel_coord_t col_pos,
    input  video_pkg::pixel_coord_t row_pos,
    input  logic                    pixel_valid,
    input  logic                    frame_start,
    output video_pkg::color_t       color,
    output logic                    color_valid
);

    traffic_pkg::lane_pos_vec_t   lane_x;
    traffic_pkg::lane_len_vec_t   lane_length;
    traffic_pkg::lane_speed_vec_t lane_speed;
    traffic_pkg::lane_pos_vec_t   next_x;
    logic                         motion_en;
    logic                         x_update;
    video_pkg::color_t            color_next;

    traffic_regs regs_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .next_x      (next_x),
        .x_update    (x_update),
        .lane_x      (lane_x),
        .lane_length (lane_length),
        .lane_speed  (lane_speed),
        .motion_en   (motion_en)
    );

    lane_motion motion_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_start (frame_start),
        .motion_en   (motion_en),
        .lane_x      (lane_x),
        .lane_length (lane_length),
        .lane_speed  (lane_speed),
        .next_x      (next_x),
        .x_update    (x_update)
    );

    vehicle_painter painter_i (
        .col_pos     (col_pos),
        .row_pos     (row_pos),
        .lane_x      (lane_x),
        .lane_length (lane_length),
        .color_next  (color_next)
    );

    // one register stage, a new pixel every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            color       <= '0;
            color_valid <= 1'b0;
        end else begin
            color_valid <= pixel_valid;
            if (pixel_valid) begin
                color <= color_next;
            end
        end
    end

endmodule

//--- vehicle_painter/vehicle_painter.sv
module vehicle_painter (
    input  video_pkg::pixel_coord_t    col_pos,
    input  video_pkg::pixel_coord_t    row_pos,
    input  traffic_pkg::lane_pos_vec_t lane_x,
    input  traffic_pkg::lane_len_vec_t lane_length,
    output video_pkg::color_t          color_next
);

    logic                    in_field;
    logic                    in_car;
    video_pkg::pixel_coord_t local_x;
    video_pkg::pixel_coord_t local_y;
    video_pkg::pixel_coord_t cur_len;
    logic [9:0]              car_addr;
    video_pkg::color_t       car_pixel;

    car_rom rom_i (
        .addr (car_addr),
        .data (car_pixel)
    );

    assign in_field = (col_pos >= video_pkg::X_OFFSET_LEFT) &&
                      (col_pos <  video_pkg::X_OFFSET_RIGHT);

    // lowest lane wins if two ever overlap
    always_comb begin
        video_pkg::pixel_coord_t lane_y;
        logic [10:0]             car_end;
        in_car  = 1'b0;
        local_x = '0;
        local_y = '0;
        cur_len = '0;
        for (int n = 0; n < traffic_pkg::NUM_LANES; n++) begin
            lane_y  = video_pkg::LANE0_Y + video_pkg::pixel_coord_t'(n) * video_pkg::BLOCKSIZE;
            // 11 bits so a vehicle near 1023 does not wrap
            car_end = {1'b0, lane_x[n]} + {1'b0, lane_length[n]};
            if (!in_car && in_field &&
                row_pos >= lane_y && row_pos < lane_y + video_pkg::BLOCKSIZE &&
                col_pos >= lane_x[n] && {1'b0, col_pos} < car_end) begin
                in_car  = 1'b1;
                local_x = col_pos - lane_x[n];
                local_y = row_pos - lane_y;
                cur_len = lane_length[n];
            end
        end
    end

    // sprite row in the upper five bits
    assign car_addr = {local_y[4:0], local_x[4:0]};

    always_comb begin
        color_next = '0;
        if (in_car) begin
            if (cur_len > video_pkg::RV_THRESHOLD) begin
                // truck
                if (local_y >= 10'd24) begin
                    color_next = video_pkg::TRUCK_BODY;
                    if ((local_x >= 10'd4 && local_x <= 10'd8) ||
                        (local_x >= cur_len - 10'd9 && local_x <= cur_len - 10'd5)) begin
                        color_next = video_pkg::WHEEL_COL;
                    end
                end else if (local_y >= 10'd10) begin
                    // cab is the front block
                    if (local_x >= cur_len - video_pkg::BLOCKSIZE) begin
                        color_next = video_pkg::TRUCK_CAB;
                        if (local_y >= 10'd12 && local_y <= 10'd16 &&
                            local_x >= cur_len - 10'd28 && local_x <= cur_len - 10'd20) begin
                            color_next = video_pkg::WINDOW_COL;
                        end
                    end else begin
                        color_next = video_pkg::TRUCK_BODY;
                    end
                end else begin
                    color_next = video_pkg::TRUCK_BODY;
                end
            end else if (cur_len == video_pkg::RV_THRESHOLD) begin
                // RV, later layers paint over earlier ones
                color_next = video_pkg::RV_BODY;
                if (local_y < 10'd4 && local_x >= 10'd4 && local_x < cur_len - 10'd4) begin
                    color_next = video_pkg::RV_ROOF;
                end
                if (local_y >= 10'd14 && local_y <= 10'd17 &&
                    local_x >= 10'd4 && local_x < cur_len - 10'd4) begin
                    color_next = video_pkg::STRIPE_1;
                end
                if (local_y == 10'd18 && local_x >= 10'd8 && local_x < cur_len - 10'd8) begin
                    color_next = video_pkg::STRIPE_2;
                end
                // two side windows
                if (local_y >= 10'd8 && local_y <= 10'd13 &&
                    ((local_x >= 10'd8 && local_x <= 10'd20) ||
                     (local_x >= 10'd24 && local_x <= 10'd36))) begin
                    color_next = video_pkg::WINDOW_COL;
                end
                // windshield
                if (local_y >= 10'd6 && local_y <= 10'd14 &&
                    local_x >= cur_len - 10'd16 && local_x <= cur_len - 10'd4) begin
                    color_next = video_pkg::WINDOW_COL;
                end
                // headlights
                if (local_y >= 10'd18 && local_y <= 10'd22 &&
                    local_x >= cur_len - 10'd5 && local_x <= cur_len - 10'd1) begin
                    color_next = video_pkg::WINDOW_COL;
                end
                if (local_y >= 10'd24 &&
                    ((local_x >= 10'd9 && local_x <= 10'd14) ||
                     (local_x >= cur_len - 10'd18 && local_x <= cur_len - 10'd12))) begin
                    color_next = video_pkg::WHEEL_COL;
                end
            end else begin
                color_next = car_pixel;
            end
        end
    end

endmodule

//--- vehicle_painter/car_rom.sv
module car_rom (
    input  logic [9:0]        addr,
    output video_pkg::color_t data
);

    logic [4:0] row;
    logic [4:0] col;

    // addr is {row, col}
    assign row = addr[9:5];
    assign col = addr[4:0];

    always_comb begin
        // wheels sit on the bottom rows
        if (row >= 5'd26 &&
            ((col >= 5'd3 && col <= 5'd8) || (col >= 5'd23 && col <= 5'd28))) begin
            data = video_pkg::WHEEL_COL;
        end else if (row >= 5'd8 && row <= 5'd13 && col >= 5'd10 && col <= 5'd21) begin
            data = video_pkg::WINDOW_COL;
        end else if (row <= 5'd5) begin
            data = video_pkg::CAR_ROOF;
        end else begin
            data = video_pkg::CAR_BODY;
        end
    end

endmodule

//--- traffic_regs/lane_motion.sv
module lane_motion (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         frame_start,
    input  logic                         motion_en,
    input  traffic_pkg::lane_pos_vec_t   lane_x,
    input  traffic_pkg::lane_len_vec_t   lane_length,
    input  traffic_pkg::lane_speed_vec_t lane_speed,
    output traffic_pkg::lane_pos_vec_t   next_x,
    output logic                         x_update
);

    traffic_pkg::lane_pos_vec_t        moved_x;
    logic [traffic_pkg::NUM_LANES-1:0] wrapped;

    always_comb begin
        logic signed [11:0] step;
        logic signed [11:0] sum;
        for (int n = 0; n < traffic_pkg::NUM_LANES; n++) begin
            step       = $signed({{6{lane_speed[n][5]}}, lane_speed[n]});
            sum        = $signed({2'b00, lane_x[n]}) + step;
            moved_x[n] = sum[9:0];
            wrapped[n] = 1'b0;
            if (step > 0) begin
                // off the right edge, restart at the left
                if (sum >= $signed({2'b00, video_pkg::X_OFFSET_RIGHT})) begin
                    moved_x[n] = video_pkg::X_OFFSET_LEFT;
                    wrapped[n] = 1'b1;
                end
            end else if (step < 0) begin
                // off the left edge, tail lands on the right edge
                if (sum < $signed({2'b00, video_pkg::X_OFFSET_LEFT})) begin
                    moved_x[n] = video_pkg::X_OFFSET_RIGHT - lane_length[n];
                    wrapped[n] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_update <= 1'b0;
        end else begin
            x_update <= frame_start && motion_en;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start && motion_en) begin
            next_x <= moved_x;
        end
    end

    for (genvar n = 0; n < traffic_pkg::NUM_LANES; n++) begin : g_wrap_chk
        // a wrapped vehicle restarts inside the playfield
        assert property (@(posedge clk) disable iff (!arst_n)
            frame_start && motion_en && wrapped[n] |=>
            next_x[n] >= video_pkg::X_OFFSET_LEFT && next_x[n] < video_pkg::X_OFFSET_RIGHT);
    end

endmodule

//--- traffic_regs/traffic_regs.sv
module traffic_regs (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  traffic_pkg::apb_addr_t       paddr,
    input  traffic_pkg::apb_data_t       pwdata,
    output traffic_pkg::apb_data_t       prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  traffic_pkg::lane_pos_vec_t   next_x,
    input  logic                         x_update,
    output traffic_pkg::lane_pos_vec_t   lane_x,
    output traffic_pkg::lane_len_vec_t   lane_length,
    output traffic_pkg::lane_speed_vec_t lane_speed,
    output logic                         motion_en
);

    traffic_pkg::lane_idx_t           lane_sel;
    logic [3:0]                       reg_off;
    logic                             aligned;
    logic                             lane_hit;
    logic                             ctrl_hit;
    logic                             addr_ok;
    logic                             access;
    logic                             wr_en;
    logic [traffic_pkg::NUM_LANES-1:0] lane_wr;
    traffic_pkg::lane_speed_t         rd_speed;

    // 16 bytes per lane
    assign lane_sel = paddr[6:4];
    assign reg_off  = paddr[3:0];
    assign aligned  = (paddr[1:0] == 2'b00);
    assign lane_hit = (paddr < traffic_pkg::REG_CTRL);
    assign ctrl_hit = (paddr == traffic_pkg::REG_CTRL);

    // offset 0xc of each window is a hole
    assign addr_ok = aligned &&
                     (ctrl_hit ||
                      (lane_hit && (reg_off == traffic_pkg::REG_X ||
                                    reg_off == traffic_pkg::REG_LEN ||
                                    reg_off == traffic_pkg::REG_SPEED)));

    // no wait states
    assign access  = psel && penable;
    assign wr_en   = access && pwrite && addr_ok;
    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;

    always_comb begin
        for (int n = 0; n < traffic_pkg::NUM_LANES; n++) begin
            lane_wr[n] = wr_en && lane_hit && (lane_sel == traffic_pkg::lane_idx_t'(n));
        end
    end

    assign rd_speed = lane_speed[lane_sel];

    always_comb begin
        prdata = '0;
        if (access && !pwrite && addr_ok) begin
            if (ctrl_hit) begin
                prdata = {31'b0, motion_en};
            end else begin
                case (reg_off)
                    traffic_pkg::REG_X:     prdata = {22'b0, lane_x[lane_sel]};
                    traffic_pkg::REG_LEN:   prdata = {22'b0, lane_length[lane_sel]};
                    // speed reads back sign extended
                    traffic_pkg::REG_SPEED: prdata = {{26{rd_speed[5]}}, rd_speed};
                    default:                prdata = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_x      <= {traffic_pkg::NUM_LANES{traffic_pkg::LANE_X_RESET}};
            lane_length <= {traffic_pkg::NUM_LANES{traffic_pkg::LANE_LEN_RESET}};
            lane_speed  <= '0;
            motion_en   <= 1'b0;
        end else begin
            for (int n = 0; n < traffic_pkg::NUM_LANES; n++) begin
                // a bus write to x beats the frame update
                if (lane_wr[n] && reg_off == traffic_pkg::REG_X) begin
                    lane_x[n] <= pwdata[9:0];
                end else if (x_update) begin
                    lane_x[n] <= next_x[n];
                end
                if (lane_wr[n] && reg_off == traffic_pkg::REG_LEN) begin
                    lane_length[n] <= pwdata[9:0];
                end
                if (lane_wr[n] && reg_off == traffic_pkg::REG_SPEED) begin
                    lane_speed[n] <= pwdata[5:0];
                end
            end
            if (wr_en && ctrl_hit) begin
                motion_en <= pwdata[0];
            end
        end
    end

    // access phase only ever follows a setup phase
    assert property (@(posedge clk) disable iff (!arst_n) penable |-> psel);

    // address holds from setup into access
    assert property (@(posedge clk) disable iff (!arst_n)
        psel && !penable |=> psel && penable && $stable(paddr));

endmodule

//--- common/traffic_pkg.sv
package traffic_pkg;

    // one vehicle per road lane
    localparam int NUM_LANES = 6;

    typedef logic [2:0] lane_idx_t;

    // signed pixels per frame, negative moves left
    typedef logic signed [5:0] lane_speed_t;

    // APB bus widths
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // per-lane vectors, lane n sits in element n
    typedef video_pkg::pixel_coord_t [NUM_LANES-1:0] lane_pos_vec_t;
    typedef video_pkg::pixel_coord_t [NUM_LANES-1:0] lane_len_vec_t;
    typedef lane_speed_t [NUM_LANES-1:0]             lane_speed_vec_t;

    // register offsets inside a 16 byte lane window
    localparam logic [3:0] REG_X     = 4'h0;
    localparam logic [3:0] REG_LEN   = 4'h4;
    localparam logic [3:0] REG_SPEED = 4'h8;

    // global control, bit 0 enables motion
    // lane windows occupy everything below it
    localparam apb_addr_t REG_CTRL = 8'h60;

    // a fresh lane holds a one block car at the left edge
    localparam video_pkg::pixel_coord_t LANE_X_RESET   = video_pkg::X_OFFSET_LEFT;
    localparam video_pkg::pixel_coord_t LANE_LEN_RESET = video_pkg::BLOCKSIZE;

endpackage

//--- common/video_pkg.sv
package video_pkg;

    // screen column or row, wide enough for 640x480 and beyond
    typedef logic [9:0] pixel_coord_t;

    // RRGGBB, two bits per channel
    typedef logic [5:0] color_t;

    // one lane is one block high
    localparam pixel_coord_t BLOCKSIZE = 10'd32;

    // playfield column bounds, right bound exclusive
    localparam pixel_coord_t X_OFFSET_LEFT  = 10'd96;
    localparam pixel_coord_t X_OFFSET_RIGHT = 10'd544;

    // first road lane row, the others follow one block apart
    localparam pixel_coord_t LANE0_Y = 10'd256;

    // above this a vehicle is a truck, exactly this an RV
    localparam pixel_coord_t RV_THRESHOLD = 10'd64;

    // car sprite colours
    localparam color_t CAR_BODY   = 6'b110000;
    localparam color_t CAR_ROOF   = 6'b000000;

    // truck colours
    localparam color_t TRUCK_BODY = 6'b001110;
    localparam color_t TRUCK_CAB  = 6'b001011;

    // RV colours
    localparam color_t RV_BODY    = 6'b101011;
    localparam color_t RV_ROOF    = 6'b111111;
    localparam color_t STRIPE_1   = 6'b111000;
    localparam color_t STRIPE_2   = 6'b000101;

    // shared details
    localparam color_t WINDOW_COL = 6'b111111;
    localparam color_t WHEEL_COL  = 6'b000001;

endpackage
